//--- common/video_pkg.sv
`default_nettype none

package video_pkg;

    // RGB565 pixel
    typedef logic [15:0] pixel_t;

    // One DRAM word, pixel 0 in the low bits
    typedef logic [127:0] chunk_t;

    typedef logic [10:0] h_count_t;
    typedef logic [9:0]  v_count_t;

    typedef struct packed {
        chunk_t data;
        logic   last;
    } chunk_beat_t;

    typedef struct packed {
        pixel_t data;
        logic   last;
    } pixel_beat_t;

    localparam int PIXELS_PER_CHUNK = 8;

    // Async FIFO sizing
    localparam int FIFO_DEPTH    = 128;
    localparam int FIFO_PROGFULL = 12;

    // Fill colour while no pixel is ready, pure red
    localparam pixel_t BLANK_PIXEL = 16'b11111_000000_00000;

endpackage

`default_nettype wire

//--- design/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
    parameter int H_ACTIVE = 1280,
    parameter int H_TOTAL  = 1650,
    parameter int V_ACTIVE = 720,
    parameter int V_TOTAL  = 750
) (
    input  wire                clk_pixel,
    input  wire                rst_n,
    output video_pkg::h_count_t h_count,
    output video_pkg::v_count_t v_count,
    output logic               active_draw
);

    import video_pkg::*;

    h_count_t h_next;
    v_count_t v_next;
    logic     h_wrap;
    logic     v_wrap;

    assign h_wrap = (int'(h_count) == H_TOTAL - 1);
    assign v_wrap = (int'(v_count) == V_TOTAL - 1);

    always_comb begin
        h_next = h_count + 1'b1;
        v_next = v_count;
        if (h_wrap) begin
            h_next = '0;
            // Line done, step to the next one
            if (v_wrap) begin
                v_next = '0;
            end else begin
                v_next = v_count + 1'b1;
            end
        end
    end

    // Flag is computed from the next position so all three move together
    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            h_count     <= '0;
            v_count     <= '0;
            active_draw <= 1'b1;
        end else begin
            h_count     <= h_next;
            v_count     <= v_next;
            active_draw <= (int'(h_next) < H_ACTIVE) && (int'(v_next) < V_ACTIVE);
        end
    end

endmodule

`default_nettype wire

//--- clockdomain_fifo/clockdomain_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module clockdomain_fifo #(
    parameter int DEPTH          = video_pkg::FIFO_DEPTH,
    parameter int PROGFULL_DEPTH = video_pkg::FIFO_PROGFULL
) (
    input  wire                        sender_clk,
    input  wire                        receiver_clk,
    input  wire                        rst_n,

    input  wire                        sender_valid,
    output logic                       sender_ready,
    input  wire video_pkg::chunk_beat_t sender_beat,
    output logic                       sender_prog_full,

    output logic                       receiver_valid,
    input  wire                        receiver_ready,
    output video_pkg::chunk_beat_t     receiver_beat
);

    import video_pkg::*;

    localparam int AW = $clog2(DEPTH);

    chunk_beat_t mem [DEPTH];

    logic [1:0]  sender_rst_sync;
    logic        sender_rst_n;
    logic [AW:0] wbin;
    logic [AW:0] wbin_next;
    logic [AW:0] wgray;
    logic [AW:0] rgray_s1;
    logic [AW:0] rgray_s2;
    logic [AW:0] used;
    logic        full;
    logic        wr_en;

    logic [1:0]  receiver_rst_sync;
    logic        receiver_rst_n;
    logic [AW:0] rbin;
    logic [AW:0] rgray;
    logic [AW:0] wgray_r1;
    logic [AW:0] wgray_r2;
    logic        empty;
    logic        rd_en;

    function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
        logic [AW:0] b;
        b[AW] = g[AW];
        for (int i = AW - 1; i >= 0; i--) begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    // Reset release synchronizers, one per domain
    always_ff @(posedge sender_clk or negedge rst_n) begin
        if (!rst_n) begin
            sender_rst_sync <= '0;
        end else begin
            sender_rst_sync <= {sender_rst_sync[0], 1'b1};
        end
    end
    assign sender_rst_n = sender_rst_sync[1];

    always_ff @(posedge receiver_clk or negedge rst_n) begin
        if (!rst_n) begin
            receiver_rst_sync <= '0;
        end else begin
            receiver_rst_sync <= {receiver_rst_sync[0], 1'b1};
        end
    end
    assign receiver_rst_n = receiver_rst_sync[1];

    // Sender side
    // Full when the pointers differ only in the two top Gray bits
    assign full         = (wgray == {~rgray_s2[AW:AW-1], rgray_s2[AW-2:0]});
    assign sender_ready = sender_rst_n && !full;
    assign wr_en        = sender_valid && sender_ready;
    assign wbin_next    = wbin + (AW + 1)'(wr_en);
    assign used         = wbin_next - gray2bin(rgray_s2);

    always_ff @(posedge sender_clk or negedge sender_rst_n) begin
        if (!sender_rst_n) begin
            wbin             <= '0;
            wgray            <= '0;
            rgray_s1         <= '0;
            rgray_s2         <= '0;
            sender_prog_full <= 1'b0;
        end else begin
            wbin             <= wbin_next;
            wgray            <= wbin_next ^ (wbin_next >> 1);
            rgray_s1         <= rgray;
            rgray_s2         <= rgray_s1;
            sender_prog_full <= (DEPTH - int'(used)) <= PROGFULL_DEPTH;
        end
    end

    always_ff @(posedge sender_clk) begin
        if (wr_en) begin
            mem[wbin[AW-1:0]] <= sender_beat;
        end
    end

    // Receiver side, output register refills whenever it drains
    assign empty = (rgray == wgray_r2);
    assign rd_en = !empty && (!receiver_valid || receiver_ready);

    always_ff @(posedge receiver_clk or negedge receiver_rst_n) begin
        if (!receiver_rst_n) begin
            rbin           <= '0;
            rgray          <= '0;
            wgray_r1       <= '0;
            wgray_r2       <= '0;
            receiver_valid <= 1'b0;
        end else begin
            wgray_r1 <= wgray;
            wgray_r2 <= wgray_r1;
            if (rd_en) begin
                rbin  <= rbin + 1'b1;
                rgray <= (rbin + 1'b1) ^ ((rbin + 1'b1) >> 1);
            end
            receiver_valid <= rd_en || (receiver_valid && !receiver_ready);
        end
    end

    always_ff @(posedge receiver_clk) begin
        if (rd_en) begin
            receiver_beat <= mem[rbin[AW-1:0]];
        end
    end

endmodule

`default_nettype wire

//--- design/unstacker.sv
`timescale 1ns/1ps
`default_nettype none

module unstacker (
    input  wire                         clk_pixel,
    input  wire                         rst_n,

    input  wire                         chunk_valid,
    output logic                        chunk_ready,
    input  wire video_pkg::chunk_beat_t chunk_beat,

    output logic                        pixel_valid,
    input  wire                         pixel_ready,
    output video_pkg::pixel_beat_t      pixel_beat
);

    import video_pkg::*;

    localparam int IDX_W = $clog2(PIXELS_PER_CHUNK);
    localparam int PIX_W = $bits(pixel_t);

    chunk_beat_t      chunk_q;
    logic [IDX_W-1:0] idx;
    logic             last_pixel;
    logic             take;
    logic             pixel_xfer;

    // Only accept a new chunk once the held one is fully drained
    assign chunk_ready = chunk_valid && !pixel_valid;
    assign take        = chunk_valid && chunk_ready;
    assign pixel_xfer  = pixel_valid && pixel_ready;
    assign last_pixel  = (int'(idx) == PIXELS_PER_CHUNK - 1);

    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            pixel_valid <= 1'b0;
            idx         <= '0;
        end else begin
            if (take) begin
                pixel_valid <= 1'b1;
                idx         <= '0;
            end else if (pixel_xfer) begin
                idx <= idx + 1'b1;
                if (last_pixel) begin
                    pixel_valid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (take) begin
            chunk_q <= chunk_beat;
        end
    end

    // Chunk last flag goes out with the final pixel only
    always_comb begin
        pixel_beat.data = chunk_q.data[idx * PIX_W +: PIX_W];
        pixel_beat.last = chunk_q.last && last_pixel;
    end

endmodule

`default_nettype wire

//--- design/dram_reader_video.sv
`timescale 1ns/1ps
`default_nettype none

module dram_reader_video (
    input  wire                         clk_pixel,
    input  wire                         clk_dram_ctrl,
    input  wire                         rst_n,

    input  wire video_pkg::h_count_t    h_count,
    input  wire video_pkg::v_count_t    v_count,
    input  wire                         active_draw,

    output video_pkg::pixel_t           pixel,

    input  wire                         s_valid,
    output logic                        s_ready,
    input  wire video_pkg::chunk_beat_t s_beat,
    output logic                        s_almost_full
);

    import video_pkg::*;

    logic        chunk_valid;
    logic        chunk_ready;
    chunk_beat_t chunk_beat;

    logic        pixel_valid;
    logic        pixel_ready;
    pixel_beat_t pixel_beat;

    clockdomain_fifo #(
        .DEPTH          (FIFO_DEPTH),
        .PROGFULL_DEPTH (FIFO_PROGFULL)
    ) i_fifo (
        .sender_clk       (clk_dram_ctrl),
        .receiver_clk     (clk_pixel),
        .rst_n            (rst_n),
        .sender_valid     (s_valid),
        .sender_ready     (s_ready),
        .sender_beat      (s_beat),
        .sender_prog_full (s_almost_full),
        .receiver_valid   (chunk_valid),
        .receiver_ready   (chunk_ready),
        .receiver_beat    (chunk_beat)
    );

    unstacker i_unstacker (
        .clk_pixel   (clk_pixel),
        .rst_n       (rst_n),
        .chunk_valid (chunk_valid),
        .chunk_ready (chunk_ready),
        .chunk_beat  (chunk_beat),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready),
        .pixel_beat  (pixel_beat)
    );

    // End of frame waits for the raster origin
    always_comb begin
        if (pixel_beat.last) begin
            pixel_ready = (h_count == '0) && (v_count == '0);
        end else begin
            pixel_ready = active_draw;
        end
    end

    assign pixel = pixel_valid ? pixel_beat.data : BLANK_PIXEL;

endmodule

`default_nettype wire

//--- design/video_reader_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_reader_top #(
    parameter int H_ACTIVE = 1280,
    parameter int H_TOTAL  = 1650,
    parameter int V_ACTIVE = 720,
    parameter int V_TOTAL  = 750
) (
    input  wire                         clk_pixel,
    input  wire                         clk_dram_ctrl,
    input  wire                         rst_n,

    input  wire                         s_valid,
    output logic                        s_ready,
    input  wire video_pkg::chunk_beat_t s_beat,
    output logic                        s_almost_full,

    output video_pkg::h_count_t         h_count,
    output video_pkg::v_count_t         v_count,
    output logic                        active_draw,
    output video_pkg::pixel_t           pixel
);

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) i_timing (
        .clk_pixel   (clk_pixel),
        .rst_n       (rst_n),
        .h_count     (h_count),
        .v_count     (v_count),
        .active_draw (active_draw)
    );

    // Reader sees the same raster that is exported
    dram_reader_video i_reader (
        .clk_pixel     (clk_pixel),
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_n         (rst_n),
        .h_count       (h_count),
        .v_count       (v_count),
        .active_draw   (active_draw),
        .pixel         (pixel),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .s_beat        (s_beat),
        .s_almost_full (s_almost_full)
    );

endmodule

`default_nettype wire

//--- testbench/video_reader_properties.sv
`timescale 1ns/1ps
`default_nettype none

module video_reader_properties (
    input wire                         clk_pixel,
    input wire                         clk_dram_ctrl,
    input wire                         rst_n,
    input wire                         s_valid,
    input wire                         s_ready,
    input wire video_pkg::chunk_beat_t s_beat,
    input wire                         s_almost_full,
    input wire                         chunk_valid,
    input wire                         chunk_ready,
    input wire video_pkg::chunk_beat_t chunk_beat,
    input wire                         pixel_valid,
    input wire                         pixel_ready,
    input wire video_pkg::pixel_beat_t pixel_beat
);

    // A stalled beat keeps its payload
    a_s_hold: assert property (@(posedge clk_dram_ctrl) disable iff (!rst_n)
        s_valid && !s_ready |=> s_valid && $stable(s_beat))
        else $error("DRAM-side word changed while stalled");

    a_chunk_hold: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        chunk_valid && !chunk_ready |=> chunk_valid && $stable(chunk_beat))
        else $error("FIFO output word changed while stalled");

    a_pixel_hold: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel_beat))
        else $error("Unstacker pixel changed while stalled");

    a_reset_state: assert property (@(posedge clk_pixel)
        !rst_n |-> !s_ready && !s_almost_full && !pixel_valid && !chunk_ready)
        else $error("Handshake outputs active during reset");

    // Almost-full comes up no later than full
    a_af_before_full: assert property (@(posedge clk_dram_ctrl) disable iff (!rst_n)
        $fell(s_ready) |-> s_almost_full)
        else $error("s_ready fell while s_almost_full was low");

endmodule

bind dram_reader_video video_reader_properties i_properties (
    .clk_pixel     (clk_pixel),
    .clk_dram_ctrl (clk_dram_ctrl),
    .rst_n         (rst_n),
    .s_valid       (s_valid),
    .s_ready       (s_ready),
    .s_beat        (s_beat),
    .s_almost_full (s_almost_full),
    .chunk_valid   (chunk_valid),
    .chunk_ready   (chunk_ready),
    .chunk_beat    (chunk_beat),
    .pixel_valid   (pixel_valid),
    .pixel_ready   (pixel_ready),
    .pixel_beat    (pixel_beat)
);

`default_nettype wire

//--- testbench/tb_video_reader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_reader;

    import video_pkg::*;

    localparam int H_ACTIVE_TB      = 16;
    localparam int H_TOTAL_TB       = 24;
    localparam int V_ACTIVE_TB      = 6;
    localparam int V_TOTAL_TB       = 9;
    localparam int PIXEL_PERIOD     = 20;
    localparam int DRAM_PERIOD      = 12;
    localparam int RESET_CYCLES     = 16;
    localparam int FRAME_CYCLES     = H_TOTAL_TB * V_TOTAL_TB;
    localparam int CHUNKS_PER_FRAME = H_ACTIVE_TB * V_ACTIVE_TB / PIXELS_PER_CHUNK;
    localparam int STEADY_FRAMES    = 3;
    localparam int SHORT_FRAMES     = 2;
    localparam int BP_FRAMES        = 14;
    localparam int TOTAL_FRAMES     = STEADY_FRAMES + SHORT_FRAMES + 1 + BP_FRAMES;
    localparam int UNDERFLOW_CYCLES = 300;
    // A frame may need two raster frames behind its held last pixel
    localparam int WATCHDOG_NS = ((2 * TOTAL_FRAMES + 10) * FRAME_CYCLES
                                  + RESET_CYCLES + UNDERFLOW_CYCLES) * PIXEL_PERIOD;
    localparam logic [31:0] SEED     = 32'h8f820de5;
    localparam pixel_t      RED_FILL = 16'hf800;

    typedef struct packed {
        logic [2:0] phase;
        logic       last;
        pixel_t     data;
    } model_entry_t;

    logic        clk_pixel;
    logic        clk_dram_ctrl;
    logic        rst_n;
    logic        s_valid;
    logic        s_ready;
    chunk_beat_t s_beat;
    logic        s_almost_full;
    h_count_t    h_count;
    v_count_t    v_count;
    logic        active_draw;
    pixel_t      pixel;

    model_entry_t model_q[$];
    logic [31:0]  lfsr;
    logic [2:0]   phase;
    int           error_count;
    int           check_count;
    int           pixel_count;
    int           frame_count;
    int           underflow_blanks;
    logic         raster_checked;
    logic         holding_last;
    logic         underflow_window;
    logic         saw_almost_full;
    logic         saw_stall;

    video_reader_top #(
        .H_ACTIVE (H_ACTIVE_TB),
        .H_TOTAL  (H_TOTAL_TB),
        .V_ACTIVE (V_ACTIVE_TB),
        .V_TOTAL  (V_TOTAL_TB)
    ) i_dut (
        .clk_pixel     (clk_pixel),
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_n         (rst_n),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .s_beat        (s_beat),
        .s_almost_full (s_almost_full),
        .h_count       (h_count),
        .v_count       (v_count),
        .active_draw   (active_draw),
        .pixel         (pixel)
    );

    always #(PIXEL_PERIOD / 2) clk_pixel = ~clk_pixel;
    always #(DRAM_PERIOD / 2) clk_dram_ctrl = ~clk_dram_ctrl;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic string phase_name(input logic [2:0] p);
        case (p)
            3'd1:    return "steady";
            3'd2:    return "short_frame";
            3'd3:    return "underflow";
            3'd4:    return "back_pressure";
            default: return "reset";
        endcase
    endfunction

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("ERR %s expected %0h actual %0h", test, expected, actual);
        end
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("%s at %0t ns", what, $time);
    endtask

    // Called and left at 2 ns after a DRAM clock edge
    task automatic send_chunk(input logic last, input bit gaps, input bit honour_af);
        chunk_t       data;
        pixel_t       px;
        model_entry_t entry;
        bit           accepted;
        int           gap;
        if (gaps) begin
            gap = int'(take_bits(2));
            repeat (gap) begin
                @(posedge clk_dram_ctrl);
                #2;
            end
        end
        while (honour_af && s_almost_full) begin
            @(posedge clk_dram_ctrl);
            #2;
        end
        for (int i = 0; i < PIXELS_PER_CHUNK; i++) begin
            // Bit 0 set keeps every value apart from the red fill
            px              = pixel_t'(take_bits(16)) | 16'h0001;
            data[i*16 +: 16] = px;
            entry.phase     = phase;
            entry.last      = last && (i == PIXELS_PER_CHUNK - 1);
            entry.data      = px;
            model_q.push_back(entry);
        end
        s_beat.data = data;
        s_beat.last = last;
        s_valid     = 1'b1;
        do begin
            if (phase == 3'd4) begin
                if (s_almost_full) begin
                    saw_almost_full = 1'b1;
                end
                if (!s_ready && !saw_stall) begin
                    saw_stall = 1'b1;
                    if (!saw_almost_full) begin
                        report_problem("s_ready fell before s_almost_full was seen high");
                    end
                end
            end
            accepted = s_ready;
            @(posedge clk_dram_ctrl);
            #2;
        end while (!accepted);
        s_valid = 1'b0;
    endtask

    task automatic send_frame(input int chunks, input bit gaps, input bit honour_af);
        for (int c = 0; c < chunks; c++) begin
            send_chunk(c == chunks - 1, gaps, honour_af);
        end
    endtask

    task automatic wait_drained();
        while (model_q.size() != 0) begin
            @(posedge clk_pixel);
        end
    endtask

    // Values between edges are what the next rising edge acts on
    always @(negedge clk_pixel) begin
        model_entry_t head;
        if (!rst_n) begin
            check_value("reset_s_ready", 32'd0, 32'(s_ready));
            check_value("reset_s_almost_full", 32'd0, 32'(s_almost_full));
            check_value("reset_pixel", 32'(RED_FILL), 32'(pixel));
        end else begin
            if (!raster_checked) begin
                raster_checked = 1'b1;
                check_value("reset_h_count", 32'd0, 32'(h_count));
                check_value("reset_v_count", 32'd0, 32'(v_count));
                check_value("reset_active_draw", 32'd1, 32'(active_draw));
            end
            if (underflow_window && active_draw && pixel == RED_FILL) begin
                underflow_blanks++;
            end
            if (pixel == RED_FILL) begin
                if (holding_last) begin
                    report_problem("Held last pixel was replaced by the fill colour");
                    holding_last = 1'b0;
                end
            end else if (model_q.size() == 0) begin
                report_problem("Pixel shown while no pixel was expected");
            end else begin
                head = model_q[0];
                check_value(phase_name(head.phase), 32'(head.data), 32'(pixel));
                if (head.last) begin
                    // End of frame only leaves at the raster origin
                    if (h_count == '0 && v_count == '0) begin
                        void'(model_q.pop_front());
                        holding_last = 1'b0;
                        pixel_count++;
                        frame_count++;
                    end else begin
                        holding_last = 1'b1;
                    end
                end else if (active_draw) begin
                    void'(model_q.pop_front());
                    pixel_count++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with %0d model pixels left",
                 WATCHDOG_NS, model_q.size());
        $display("checks %0d, errors %0d, pixels %0d, frames %0d",
                 check_count, error_count, pixel_count, frame_count);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk_pixel        = 1'b0;
        clk_dram_ctrl    = 1'b0;
        rst_n            = 1'b0;
        s_valid          = 1'b0;
        s_beat           = '0;
        lfsr             = SEED;
        phase            = 3'd0;
        error_count      = 0;
        check_count      = 0;
        pixel_count      = 0;
        frame_count      = 0;
        underflow_blanks = 0;
        raster_checked   = 1'b0;
        holding_last     = 1'b0;
        underflow_window = 1'b0;
        saw_almost_full  = 1'b0;
        saw_stall        = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk_pixel);
        #2;
        rst_n = 1'b1;
        @(posedge clk_dram_ctrl);
        #2;

        phase = 3'd1;
        repeat (STEADY_FRAMES) send_frame(CHUNKS_PER_FRAME, 1'b1, 1'b1);

        phase = 3'd2;
        repeat (SHORT_FRAMES) send_frame(1 + int'(take_bits(3)), 1'b1, 1'b1);

        // Half a frame, then the source goes quiet
        phase = 3'd3;
        for (int i = 0; i < CHUNKS_PER_FRAME / 2; i++) begin
            send_chunk(1'b0, 1'b1, 1'b1);
        end
        wait_drained();
        underflow_window = 1'b1;
        repeat (UNDERFLOW_CYCLES) @(posedge clk_pixel);
        underflow_window = 1'b0;
        if (underflow_blanks == 0) begin
            report_problem("No fill colour shown while the source was stalled");
        end
        @(posedge clk_dram_ctrl);
        #2;
        for (int i = 0; i < CHUNKS_PER_FRAME / 2; i++) begin
            send_chunk(i == CHUNKS_PER_FRAME / 2 - 1, 1'b1, 1'b1);
        end

        phase = 3'd4;
        repeat (BP_FRAMES) send_frame(CHUNKS_PER_FRAME, 1'b0, 1'b0);
        wait_drained();
        if (!saw_stall) begin
            report_problem("s_ready never fell while the source ignored s_almost_full");
        end
        repeat (FRAME_CYCLES) @(posedge clk_pixel);

        $display("checks %0d, errors %0d, pixels %0d, frames %0d",
                 check_count, error_count, pixel_count, frame_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
common/video_pkg.sv
design/video_timing.sv
clockdomain_fifo/clockdomain_fifo.sv
design/unstacker.sv
design/dram_reader_video.sv
design/video_reader_top.sv
testbench/video_reader_properties.sv
testbench/tb_video_reader.sv

//--- Makefile
SIM  := obj_dir/Vtb_video_reader
SRCS := $(shell cat list.f)

.PHONY: all run clean

all: run

$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_video_reader -f list.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
